//--- Bender.yml
package:
  name: rs_slice

sources:
  - rtl/rs_pkg.sv
  - rtl/reservation_station.sv
  - rtl/occupancy_counter.sv
  - rtl/flush_sequencer.sv
  - rtl/int_alu.sv
  - rtl/rs_slice_top.sv
  - target: simulation
    files:
      - tests/tb_rs_slice.sv

//--- rtl/flush_sequencer.sv
// Flush control FSM: clears the station, kills the ALU stage and returns flushed credits
`timescale 1ns/1ps

module flush_sequencer
    import rs_pkg::*;
(
    input  logic clk,
    input  logic n_rst,
    input  logic flush,
    input  logic return_zero,
    output logic rs_clear,
    output logic alu_kill,
    output logic load_return,
    output logic return_step,
    output logic return_pulse,
    output logic flush_busy
);

    flush_state_t state;
    flush_state_t state_next;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state <= FS_RUN;
        end else begin
            state <= state_next;
        end
    end

    // A flush request is only taken while running normally
    // From FS_KILL the return phase is skipped when the station was empty
    always_comb begin
        state_next = state;
        case (state)
            FS_RUN: begin
                if (flush) begin
                    state_next = FS_KILL;
                end
            end
            FS_KILL: begin
                state_next = return_zero ? FS_RUN : FS_RETURN;
            end
            FS_RETURN: begin
                if (return_zero) begin
                    state_next = FS_RUN;
                end
            end
            default: begin
                state_next = FS_RUN;
            end
        endcase
    end

    // Clear, kill and counter load all happen in the single FS_KILL cycle
    assign rs_clear    = (state == FS_KILL);
    assign alu_kill    = (state == FS_KILL);
    assign load_return = (state == FS_KILL);

    // One credit per cycle while any are owed
    assign return_pulse = (state == FS_RETURN) && !return_zero;
    assign return_step  = return_pulse;

    assign flush_busy = (state != FS_RUN);

endmodule

//--- rtl/int_alu.sv
// Single-stage integer ALU for OP and OP-IMM, registering its result onto the CDB
`timescale 1ns/1ps

module int_alu
    import rs_pkg::*;
(
    input  logic      clk,
    input  logic      n_rst,
    input  logic      alu_kill,
    input  fu_issue_t issue,
    output cdb_t      cdb
);

    logic [2:0]        funct3;
    logic              is_sub;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] result;
    logic              stage_valid;
    logic [TAG_W-1:0]  stage_tag;
    logic [DATA_W-1:0] stage_data;

    // The immediate form takes its operand from the word itself, sign-extended
    // Subtract exists only in the register form, flagged by funct7 bit 5
    always_comb begin
        if (issue.opcode == OPCODE_OPIMM) begin
            funct3 = issue.insn.i.funct3;
            op_b   = {{(DATA_W - 12){issue.insn.i.imm12[11]}}, issue.insn.i.imm12};
            is_sub = 1'b0;
        end else begin
            funct3 = issue.insn.r.funct3;
            op_b   = issue.src_b;
            is_sub = issue.insn.r.funct7[5];
        end
    end

    // Shift encodings are not supported and give zero
    always_comb begin
        case (funct3)
            3'b000: result = is_sub ? issue.src_a - op_b : issue.src_a + op_b;
            3'b010: result = {{(DATA_W - 1){1'b0}}, $signed(issue.src_a) < $signed(op_b)};
            3'b011: result = {{(DATA_W - 1){1'b0}}, issue.src_a < op_b};
            3'b100: result = issue.src_a ^ op_b;
            3'b110: result = issue.src_a | op_b;
            3'b111: result = issue.src_a & op_b;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= issue.valid;
        end
    end

    // Result and tag only move when something issues
    always_ff @(posedge clk) begin
        if (issue.valid) begin
            stage_tag  <= issue.tag;
            stage_data <= result;
        end
    end

    // A kill drops whatever sits in the stage so it never reaches the bus
    assign cdb.valid = stage_valid && !alu_kill;
    assign cdb.tag   = stage_tag;
    assign cdb.data  = stage_data;

endmodule

//--- rtl/occupancy_counter.sv
// Tracks occupied station slots and counts down the credits still owed after a flush
`timescale 1ns/1ps

module occupancy_counter #(
    parameter int RS_DEPTH = 8
) (
    input  logic clk,
    input  logic n_rst,
    input  logic dispatch_fire,
    input  logic issue_fire,
    input  logic load_return,
    input  logic return_step,
    output logic return_zero
);

    localparam int CNT_W = $clog2(RS_DEPTH + 1);

    logic [CNT_W-1:0] occ;
    logic [CNT_W-1:0] owed;

    // The load takes the occupancy from before the clear and starts it over at zero
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            occ  <= '0;
            owed <= '0;
        end else if (load_return) begin
            owed <= occ;
            occ  <= '0;
        end else begin
            if (return_step) begin
                owed <= owed - 1'b1;
            end
            if (dispatch_fire && !issue_fire) begin
                occ <= occ + 1'b1;
            end else if (issue_fire && !dispatch_fire) begin
                occ <= occ - 1'b1;
            end
        end
    end

    // During the load cycle the answer already reflects what is about to be owed,
    // which lets the sequencer skip the return phase for an empty station
    assign return_zero = load_return ? (occ == '0) : (owed == '0);

    a_occ_bound: assert property (@(posedge clk) disable iff (!n_rst) occ <= CNT_W'(RS_DEPTH))
        else $error("occupancy count exceeds station depth");

    // The sequencer must never step past zero
    a_step_owed: assert property (@(posedge clk) disable iff (!n_rst) return_step |-> owed != '0)
        else $error("credit returned while none was owed");

endmodule

//--- rtl/reservation_station.sv
// Eight-slot (by default) reservation station with CDB wake-up and oldest-ready issue
`timescale 1ns/1ps

module reservation_station
    import rs_pkg::*;
#(
    parameter int RS_DEPTH = 8
) (
    input  logic         clk,
    input  logic         n_rst,
    input  logic         rs_clear,
    input  logic         dispatch_valid,
    input  rs_dispatch_t dispatch,
    input  cdb_t         cdb,
    output fu_issue_t    issue,
    output logic         dispatch_fire,
    output logic         full
);

    localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

    // Slot payload is the dispatched instruction itself, with ready bits and
    // operand data later overwritten by CDB captures
    rs_dispatch_t        slot [RS_DEPTH];
    logic [IDX_W-1:0]    age  [RS_DEPTH];
    logic [RS_DEPTH-1:0] older [RS_DEPTH];
    logic [RS_DEPTH-1:0] slot_empty;
    logic [RS_DEPTH-1:0] issue_ready;
    logic [RS_DEPTH-1:0] issue_sel;
    logic [RS_DEPTH-1:0] dispatch_sel;
    logic [IDX_W-1:0]    issue_idx;
    logic                issuing;

    // Lowest-numbered empty slot as a one-hot vector
    assign dispatch_sel  = slot_empty & ~(slot_empty - 1'b1);
    assign full          = ~|slot_empty;
    assign dispatch_fire = dispatch_valid && !full && !rs_clear;

    // Row i of the age matrix is set where slot i is at least as old as slot j
    // A slot is a candidate once it holds an instruction with both operands
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            for (int j = 0; j < RS_DEPTH; j++) begin
                older[i][j] = (i == j) || (age[i] > age[j]);
            end
            issue_ready[i] = !slot_empty[i] && (&slot[i].src_rdy);
        end
    end

    // Comparisons against slots that are not ready are masked off, so only
    // the oldest candidate survives
    // Nothing issues in the cycle the station is being cleared
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            issue_sel[i] = issue_ready[i] && (&(older[i] | ~issue_ready)) && !rs_clear;
        end
    end

    assign issuing = |issue_sel;

    // One-hot select to slot index
    always_comb begin
        issue_idx = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (issue_sel[i]) begin
                issue_idx = issue_idx | IDX_W'(i);
            end
        end
    end

    // The ALU sees an all-zero bundle when no slot issues
    always_comb begin
        issue = '0;
        if (issuing) begin
            issue.valid  = 1'b1;
            issue.opcode = slot[issue_idx].opcode;
            issue.insn   = slot[issue_idx].insn;
            issue.src_a  = slot[issue_idx].src_data[0];
            issue.src_b  = slot[issue_idx].src_data[1];
            issue.tag    = slot[issue_idx].dst_tag;
        end
    end

    // Occupancy per slot; a clear empties everything at once
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            slot_empty <= '1;
        end else if (rs_clear) begin
            slot_empty <= '1;
        end else begin
            slot_empty <= (slot_empty | issue_sel) & ~(dispatch_sel & {RS_DEPTH{dispatch_fire}});
        end
    end

    // Ages behave as in a linear shifting station where age 0 is the youngest
    // On dispatch alone every other slot gets older
    // On issue alone the slots older than the issuer close the gap it leaves
    // On both, only the slots younger than the issuer move up
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                case ({dispatch_fire, issuing})
                    2'b01: begin
                        if (age[i] > age[issue_idx]) begin
                            age[i] <= age[i] - 1'b1;
                        end
                    end
                    2'b10: begin
                        age[i] <= dispatch_sel[i] ? '0 : age[i] + 1'b1;
                    end
                    2'b11: begin
                        if (dispatch_sel[i]) begin
                            age[i] <= '0;
                        end else if (age[i] < age[issue_idx]) begin
                            age[i] <= age[i] + 1'b1;
                        end
                    end
                    default: begin
                        age[i] <= age[i];
                    end
                endcase
            end
        end
    end

    // Dispatch writes the whole slot; a broadcast in the same cycle is caught
    // here too, otherwise the slot would wait for a tag that has already passed
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (dispatch_fire && dispatch_sel[i]) begin
                slot[i] <= dispatch;
                for (int k = 0; k < 2; k++) begin
                    if (cdb.valid && !dispatch.src_rdy[k] && cdb.tag == dispatch.src_tag[k]) begin
                        slot[i].src_rdy[k]  <= 1'b1;
                        slot[i].src_data[k] <= cdb.data;
                    end
                end
            end else begin
                // Only operands still waiting take the broadcast value
                for (int k = 0; k < 2; k++) begin
                    if (cdb.valid && !slot[i].src_rdy[k] && cdb.tag == slot[i].src_tag[k]) begin
                        slot[i].src_rdy[k]  <= 1'b1;
                        slot[i].src_data[k] <= cdb.data;
                    end
                end
            end
        end
    end

    // At most one slot wins the age comparison
    a_issue_onehot: assert property (@(posedge clk) disable iff (!n_rst) $onehot0(issue_sel))
        else $error("issue select is not one-hot");

    // The credit scheme must keep the dispatcher away from a full station
    a_no_dispatch_full: assert property (
        @(posedge clk) disable iff (!n_rst) dispatch_valid |-> !full
    ) else $error("dispatch arrived while the station was full");

endmodule

//--- rtl/rs_pkg.sv
// Shared opcode, instruction and bus types for the issue slice; import by wildcard where needed
package rs_pkg;

    // Datapath and tag widths that every struct below is built on
    localparam int DATA_W = 32;
    localparam int TAG_W  = 6;

    // Only the two integer register forms are decoded by this slice
    typedef enum logic [6:0] {
        OPCODE_OP    = 7'b0110011,
        OPCODE_OPIMM = 7'b0010011
    } opcode_t;

    // Register-register view of the instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } insn_r_t;

    // Register-immediate view of the same word
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } insn_i_t;

    // The ALU picks the view that matches the opcode
    typedef union packed {
        insn_r_t r;
        insn_i_t i;
    } insn_u;

    // One instruction as handed over by the dispatcher
    // Index 0 is source A and index 1 is source B
    typedef struct packed {
        opcode_t                      opcode;
        insn_u                        insn;
        logic [1:0]                   src_rdy;
        logic [1:0][DATA_W-1:0]       src_data;
        logic [1:0][TAG_W-1:0]        src_tag;
        logic [TAG_W-1:0]             dst_tag;
    } rs_dispatch_t;

    // One instruction leaving the station for the ALU
    typedef struct packed {
        logic              valid;
        opcode_t           opcode;
        insn_u             insn;
        logic [DATA_W-1:0] src_a;
        logic [DATA_W-1:0] src_b;
        logic [TAG_W-1:0]  tag;
    } fu_issue_t;

    // Common data bus, a single producer with no back-pressure
    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] data;
    } cdb_t;

    // Flush sequencer states
    typedef enum logic [1:0] {
        FS_RUN,
        FS_KILL,
        FS_RETURN
    } flush_state_t;

endpackage

//--- rtl/rs_slice_top.sv
// Integer issue slice top: station, occupancy counter, flush FSM and ALU with merged credits
`timescale 1ns/1ps

module rs_slice_top
    import rs_pkg::*;
#(
    parameter int RS_DEPTH = 8
) (
    input  logic         clk,
    input  logic         n_rst,
    input  logic         flush,
    input  logic         dispatch_valid,
    input  rs_dispatch_t dispatch,
    output logic         credit_return,
    output logic         flush_busy,
    output cdb_t         cdb
);

    fu_issue_t issue;
    logic      dispatch_fire;
    logic      rs_clear;
    logic      alu_kill;
    logic      load_return;
    logic      return_step;
    logic      return_pulse;
    logic      return_zero;

    // Fullness is checked inside the station; the dispatcher relies on credits
    reservation_station #(.RS_DEPTH(RS_DEPTH)) u_rs (
        .clk           (clk),
        .n_rst         (n_rst),
        .rs_clear      (rs_clear),
        .dispatch_valid(dispatch_valid),
        .dispatch      (dispatch),
        .cdb           (cdb),
        .issue         (issue),
        .dispatch_fire (dispatch_fire),
        .full          ()
    );

    occupancy_counter #(.RS_DEPTH(RS_DEPTH)) u_occ (
        .clk          (clk),
        .n_rst        (n_rst),
        .dispatch_fire(dispatch_fire),
        .issue_fire   (issue.valid),
        .load_return  (load_return),
        .return_step  (return_step),
        .return_zero  (return_zero)
    );

    flush_sequencer u_seq (
        .clk         (clk),
        .n_rst       (n_rst),
        .flush       (flush),
        .return_zero (return_zero),
        .rs_clear    (rs_clear),
        .alu_kill    (alu_kill),
        .load_return (load_return),
        .return_step (return_step),
        .return_pulse(return_pulse),
        .flush_busy  (flush_busy)
    );

    int_alu u_alu (
        .clk     (clk),
        .n_rst   (n_rst),
        .alu_kill(alu_kill),
        .issue   (issue),
        .cdb     (cdb)
    );

    // Each issue frees a slot and each flushed slot is paid back later
    assign credit_return = issue.valid || return_pulse;

    // Issue and flush return can never overlap, or a credit would be lost
    a_credit_merge: assert property (
        @(posedge clk) disable iff (!n_rst) !(issue.valid && return_pulse)
    ) else $error("issue and flush credit return in the same cycle");

    // Station must stay quiet for the whole flush
    a_no_issue_busy: assert property (@(posedge clk) disable iff (!n_rst) flush_busy |-> !issue.valid)
        else $error("issue while a flush is in progress");

endmodule

//--- tb.f
rtl/rs_pkg.sv
rtl/reservation_station.sv
rtl/occupancy_counter.sv
rtl/flush_sequencer.sv
rtl/int_alu.sv
rtl/rs_slice_top.sv
tests/tb_rs_slice.sv

//--- tests/tb_rs_slice.sv
// Testbench for the issue slice: table-driven dispatch under a credit model, checked on the CDB
`timescale 1ns/1ps

module tb_rs_slice
    import rs_pkg::*;
;

    localparam int RS_DEPTH   = 8;
    localparam int CLK_PERIOD = 20;
    localparam int NROWS      = 17 + RS_DEPTH + 3;

    // One table row; hi is funct7 and rs2 for OP, or imm12 for OP-IMM
    // Bit 0 of rdy and ta belong to source A, the others to source B
    typedef struct packed {
        opcode_t           op;
        logic [2:0]        f3;
        logic [11:0]       hi;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [1:0]        rdy;
        logic [TAG_W-1:0]  ta;
        logic [TAG_W-1:0]  tb;
        logic [TAG_W-1:0]  dst;
        logic              fl;
    } row_t;

    logic         clk = 1'b0;
    logic         n_rst;
    logic         flush;
    logic         dispatch_valid;
    rs_dispatch_t dispatch;
    logic         credit_return;
    logic         flush_busy;
    cdb_t         cdb;

    row_t              rows [NROWS];
    logic [DATA_W-1:0] exp_val [64];
    bit                exp_known [64];
    bit                pending [64];
    bit                seen [64];
    bit                inorder [64];
    logic [TAG_W-1:0]  order_q [$];
    int                credits;
    int                pend_cnt;
    int                n_stuck;

    always #(CLK_PERIOD / 2) clk = ~clk;

    rs_slice_top #(.RS_DEPTH(RS_DEPTH)) DUT (
        .clk           (clk),
        .n_rst         (n_rst),
        .flush         (flush),
        .dispatch_valid(dispatch_valid),
        .dispatch      (dispatch),
        .credit_return (credit_return),
        .flush_busy    (flush_busy),
        .cdb           (cdb)
    );

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_cdb(input cdb_t got, input cdb_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] cdb got valid=%h tag=%h data=%h expected valid=%h tag=%h data=%h",
                got.valid, got.tag, got.data, exp.valid, exp.tag, exp.data));
        end
    endtask

    task automatic check_credits(input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("[FAIL] credits got %h expected %h", got, exp));
        end
    endtask

    task automatic check_state(input flush_state_t got, input flush_state_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] flush state got %h (%s) expected %h (%s)",
                got, got.name(), exp, exp.name()));
        end
    endtask

    // Reference integer ALU written from the instruction encoding
    // Bit 10 of hi is bit 5 of funct7, which selects subtract
    function automatic logic [DATA_W-1:0] ref_alu(opcode_t op, logic [2:0] f3, logic [11:0] hi,
                                                  logic [DATA_W-1:0] a, logic [DATA_W-1:0] b);
        logic [DATA_W-1:0] rhs;
        logic              sub;
        rhs = (op == OPCODE_OPIMM) ? {{(DATA_W - 12){hi[11]}}, hi} : b;
        sub = (op == OPCODE_OP) && hi[10];
        case (f3)
            3'd0: return sub ? a - rhs : a + rhs;
            3'd2: return DATA_W'($signed(a) < $signed(rhs));
            3'd3: return DATA_W'(a < rhs);
            3'd4: return a ^ rhs;
            3'd6: return a | rhs;
            3'd7: return a & rhs;
            default: return '0;
        endcase
    endfunction

    // Results that depend on other rows are resolved pass by pass, so a row may
    // name a producer that comes later in the table
    task automatic resolve_expected();
        row_t              w;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        repeat (NROWS) begin
            for (int r = 0; r < NROWS; r++) begin
                w = rows[r];
                a = w.rdy[0] ? w.a : exp_val[w.ta];
                b = w.rdy[1] ? w.b : exp_val[w.tb];
                if (!exp_known[w.dst] && (w.rdy[0] || exp_known[w.ta])
                        && (w.rdy[1] || exp_known[w.tb])) begin
                    exp_val[w.dst]   = ref_alu(w.op, w.f3, w.hi, a, b);
                    exp_known[w.dst] = 1'b1;
                end
            end
        end
    endtask

    // Every CDB result must be outstanding; rows ready at dispatch leave in dispatch order
    task automatic score_cdb(input cdb_t got);
        cdb_t             exp;
        logic [TAG_W-1:0] t;
        if (!pending[got.tag]) begin
            abort_run($sformatf("CDB carried tag %0d, which had no result outstanding", got.tag));
        end
        t = inorder[got.tag] ? order_q.pop_front() : got.tag;
        exp.valid = 1'b1;
        exp.tag   = t;
        exp.data  = exp_val[t];
        check_cdb(got, exp);
        pending[got.tag] = 1'b0;
        seen[got.tag]    = 1'b1;
        pend_cnt--;
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (n_rst) begin
            if (credit_return) begin
                credits++;
            end
            if (cdb.valid) begin
                score_cdb(cdb);
            end
        end
    end

    // The dispatcher holds a credit per free slot and reads results it has seen
    // from the register file instead of waiting for them
    task automatic dispatch_row(input int r);
        rs_dispatch_t d;
        row_t         w;
        w = rows[r];
        while (credits == 0 || flush_busy) begin
            @(posedge clk);
            #1;
        end
        d = '0;
        d.opcode            = w.op;
        d.insn.i.imm12      = w.hi;
        d.insn.i.rs1        = 5'(r);
        d.insn.i.funct3     = w.f3;
        d.insn.i.rd         = 5'(r);
        d.insn.i.opcode     = w.op;
        d.src_rdy           = w.rdy;
        d.src_data          = {w.b, w.a};
        d.src_tag           = {w.tb, w.ta};
        d.dst_tag           = w.dst;
        for (int k = 0; k < 2; k++) begin
            if (!d.src_rdy[k] && seen[d.src_tag[k]]) begin
                d.src_rdy[k]  = 1'b1;
                d.src_data[k] = exp_val[d.src_tag[k]];
            end
        end
        if (&d.src_rdy) begin
            inorder[w.dst] = 1'b1;
            order_q.push_back(w.dst);
        end
        if (exp_known[w.dst]) begin
            pending[w.dst] = 1'b1;
            pend_cnt++;
        end else begin
            n_stuck++;
        end
        dispatch       = d;
        dispatch_valid = 1'b1;
        credits--;
        @(posedge clk);
        #1;
        dispatch_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (pend_cnt != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Stuck slots hold the only missing credits; the flush must pay them all back
    // With slots owed the FSM passes through the return phase after the kill
    task automatic run_flush();
        wait_drained();
        check_credits(credits, RS_DEPTH - n_stuck);
        check_state(DUT.u_seq.state, FS_RUN);
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        check_state(DUT.u_seq.state, FS_KILL);
        @(posedge clk);
        #1;
        check_state(DUT.u_seq.state, (n_stuck != 0) ? FS_RETURN : FS_RUN);
        while (flush_busy) begin
            @(posedge clk);
            #1;
        end
        check_credits(credits, RS_DEPTH);
        n_stuck = 0;
    endtask

    initial begin
        rows[0]  = '{OPCODE_OP,    3'd0, 12'h000, 32'd5,        32'd7,        2'b11, 6'd0,  6'd0,  6'd1,  1'b0};
        rows[1]  = '{OPCODE_OP,    3'd0, 12'h400, 32'd3,        32'd10,       2'b11, 6'd0,  6'd0,  6'd2,  1'b0};
        rows[2]  = '{OPCODE_OPIMM, 3'd0, 12'hffb, 32'd100,      32'd0,        2'b11, 6'd0,  6'd0,  6'd3,  1'b0};
        rows[3]  = '{OPCODE_OP,    3'd7, 12'h000, 32'hf0f01234, 32'h0ff0ff00, 2'b11, 6'd0,  6'd0,  6'd4,  1'b0};
        rows[4]  = '{OPCODE_OP,    3'd6, 12'h000, 32'h12000034, 32'h00567800, 2'b11, 6'd0,  6'd0,  6'd5,  1'b0};
        rows[5]  = '{OPCODE_OPIMM, 3'd4, 12'h8ff, 32'h00000064, 32'd0,        2'b11, 6'd0,  6'd0,  6'd6,  1'b0};
        rows[6]  = '{OPCODE_OP,    3'd2, 12'h000, 32'hfffffffd, 32'd2,        2'b11, 6'd0,  6'd0,  6'd7,  1'b0};
        rows[7]  = '{OPCODE_OP,    3'd3, 12'h000, 32'hfffffffd, 32'd2,        2'b11, 6'd0,  6'd0,  6'd8,  1'b0};
        rows[8]  = '{OPCODE_OPIMM, 3'd2, 12'hfff, 32'd5,        32'd0,        2'b11, 6'd0,  6'd0,  6'd9,  1'b0};
        // A producer followed by consumers that wait on its tag
        rows[9]  = '{OPCODE_OP,    3'd0, 12'h400, 32'd50,       32'd8,        2'b11, 6'd0,  6'd0,  6'd10, 1'b0};
        rows[10] = '{OPCODE_OPIMM, 3'd0, 12'h003, 32'd0,        32'd0,        2'b10, 6'd10, 6'd0,  6'd11, 1'b0};
        rows[11] = '{OPCODE_OP,    3'd0, 12'h000, 32'd0,        32'd0,        2'b00, 6'd2,  6'd11, 6'd12, 1'b0};
        // An old slot waits on tag 20 while younger ready slots pass it
        rows[12] = '{OPCODE_OP,    3'd0, 12'h000, 32'd0,        32'd4,        2'b10, 6'd20, 6'd0,  6'd13, 1'b0};
        rows[13] = '{OPCODE_OP,    3'd4, 12'h000, 32'haaaa5555, 32'hffff0000, 2'b11, 6'd0,  6'd0,  6'd14, 1'b0};
        rows[14] = '{OPCODE_OPIMM, 3'd7, 12'h0f0, 32'h12345678, 32'd0,        2'b11, 6'd0,  6'd0,  6'd15, 1'b0};
        rows[15] = '{OPCODE_OP,    3'd6, 12'h000, 32'h00000300, 32'h00000021, 2'b11, 6'd0,  6'd0,  6'd20, 1'b0};
        rows[16] = '{OPCODE_OPIMM, 3'd3, 12'h800, 32'd0,        32'd0,        2'b10, 6'd13, 6'd0,  6'd16, 1'b0};
        // A full station waiting on a tag nobody produces, then a flush
        for (int i = 0; i < RS_DEPTH; i++) begin
            rows[17 + i] = '{OPCODE_OP, 3'd0, 12'h000, 32'd0, 32'd0, 2'b00, 6'd63, 6'd63,
                             TAG_W'(30 + i), (i == RS_DEPTH - 1)};
        end
        rows[NROWS-3] = '{OPCODE_OP,    3'd0, 12'h400, 32'd1,        32'd2,        2'b11, 6'd0, 6'd0, 6'd40, 1'b0};
        rows[NROWS-2] = '{OPCODE_OPIMM, 3'd0, 12'h001, 32'h7fffffff, 32'd0,        2'b11, 6'd0, 6'd0, 6'd41, 1'b0};
        rows[NROWS-1] = '{OPCODE_OP,    3'd3, 12'h000, 32'd1,        32'hffffffff, 2'b11, 6'd0, 6'd0, 6'd42, 1'b0};

        void'($urandom(32'hf65f_c2b9));
        n_rst          = 1'b0;
        flush          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        credits        = RS_DEPTH;
        pend_cnt       = 0;
        n_stuck        = 0;
        resolve_expected();
        repeat (10) @(posedge clk);
        #1;
        n_rst = 1'b1;
        if (cdb.valid || credit_return || flush_busy) begin
            abort_run("Outputs were not idle after reset");
        end

        for (int r = 0; r < NROWS; r++) begin
            repeat ($urandom % 3) begin
                @(posedge clk);
                #1;
            end
            dispatch_row(r);
            if (rows[r].fl) begin
                run_flush();
            end
        end
        wait_drained();
        check_credits(credits, RS_DEPTH);
        $display("Simulation passed");
        $finish;
    end

    // Fifty cycles per row bounds every wait above
    initial begin
        #((NROWS * 50 + 20) * CLK_PERIOD);
        abort_run("Watchdog expired before all rows were dispatched and retired");
    end

endmodule
